// ==== source/i3c_tx_pkg.sv ====
`default_nettype none

package i3c_tx_pkg;

    // ==========================================================================
    // serializer mode encoding
    // ==========================================================================
    // ack, nack and hold-zero are kept so the encoding lines up with the
    // full controller, this transmit path never selects them
    typedef enum logic [2:0] {
        START_BIT      = 3'b000,
        SERIALIZING    = 3'b001,
        STOP           = 3'b010,
        PARITY         = 3'b011,
        HOLD_ZERO      = 3'b100,
        CTRL_NACK      = 3'b101,
        REPEATED_START = 3'b110,
        CTRL_ACK       = 3'b111
    } ser_mode_e;

    // frame configuration as written by the host
    typedef struct packed {
        logic [7:0] data;
        logic       rep_start;
    } tx_cfg_t;

    // ==========================================================================
    // timing
    // ==========================================================================
    // i_clk cycles per scl half period
    localparam int SCL_HALF_CYC = 4;
    localparam int SCL_CNT_W    = 3;

    // sda low with scl high before the first scl fall
    localparam int START_HOLD_CYC = 6;
    localparam int START_CNT_W    = 3;

    // host register map
    localparam logic REG_DATA = 1'b0;
    localparam logic REG_CTRL = 1'b1;

endpackage

`default_nettype wire

// ==== source/tx_cfg_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module tx_cfg_regs
    import i3c_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_en,
    input  logic       i_wr_addr,
    input  logic [7:0] i_wr_data,
    output tx_cfg_t    o_cfg,
    output logic       o_go
);

    // ctrl register layout
    //   bit 0 : end the frame with a repeated start
    //   bit 1 : go, self clearing
    //   bits 7:2 are ignored

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_cfg <= '0;
            o_go  <= 1'b0;
        end
        else
        begin
            // go is only ever a single cycle strobe
            o_go <= 1'b0;
            if (i_wr_en)
            begin
                case (i_wr_addr)
                    REG_DATA:
                    begin
                        o_cfg.data <= i_wr_data;
                    end
                    REG_CTRL:
                    begin
                        o_cfg.rep_start <= i_wr_data[0];
                        o_go            <= i_wr_data[1];
                    end
                    default:
                    begin
                        o_go <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/scl_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module scl_gen
    import i3c_tx_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_run,
    output logic o_scl,
    output logic o_scl_pos_edge,
    output logic o_scl_neg_edge
);

    logic [SCL_CNT_W-1:0] half_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            half_cnt       <= '0;
            o_scl          <= 1'b1;
            o_scl_pos_edge <= 1'b0;
            o_scl_neg_edge <= 1'b0;
        end
        else if (!i_run)
        begin
            // parked high, start and stop are formed on sda alone
            half_cnt       <= '0;
            o_scl          <= 1'b1;
            o_scl_pos_edge <= 1'b0;
            o_scl_neg_edge <= 1'b0;
        end
        else if (half_cnt == SCL_CNT_W'(SCL_HALF_CYC - 1))
        begin
            half_cnt       <= '0;
            o_scl          <= ~o_scl;
            // strobes line up with the cycle in which scl changes
            o_scl_pos_edge <= ~o_scl;
            o_scl_neg_edge <= o_scl;
        end
        else
        begin
            half_cnt       <= half_cnt + 1'b1;
            o_scl_pos_edge <= 1'b0;
            o_scl_neg_edge <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/start_hold_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module start_hold_timer
    import i3c_tx_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start_pattern,
    output logic o_timer_cas
);

    logic [START_CNT_W-1:0] hold_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            hold_cnt    <= '0;
            o_timer_cas <= 1'b0;
        end
        else if (!i_start_pattern)
        begin
            hold_cnt    <= '0;
            o_timer_cas <= 1'b0;
        end
        else
        begin
            // saturate so cas fires once per start request
            if (hold_cnt != START_CNT_W'(START_HOLD_CYC))
            begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            o_timer_cas <= (hold_cnt == START_CNT_W'(START_HOLD_CYC - 1));
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_sequencer
    import i3c_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  tx_cfg_t    i_cfg,
    input  logic       i_go,
    input  logic       i_scl_pos_edge,
    input  logic       i_scl_neg_edge,
    input  logic       i_ser_mode_done,
    output logic       o_ser_en,
    output ser_mode_e  o_ser_mode,
    output logic [2:0] o_ser_count,
    output logic       o_ser_count_done,
    output logic [7:0] o_ser_data,
    output logic       o_scl_run,
    output logic       o_busy,
    output logic       o_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_END
    } seq_state_e;

    seq_state_e state;
    tx_cfg_t    cfg_q;
    // the scl fall that closes the start hold does not advance the count
    logic       first_fall;

    // byte and ending choice frozen for the whole frame
    always_ff @(posedge i_clk)
    begin
        if (state == ST_IDLE && i_go)
        begin
            cfg_q <= i_cfg;
        end
    end

    assign o_ser_data = cfg_q.data;

    // ==========================================================================
    // frame FSM
    // ==========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state            <= ST_IDLE;
            first_fall       <= 1'b0;
            o_ser_en         <= 1'b0;
            o_ser_mode       <= START_BIT;
            o_ser_count      <= 3'd0;
            o_ser_count_done <= 1'b0;
            o_scl_run        <= 1'b0;
            o_busy           <= 1'b0;
            o_done           <= 1'b0;
        end
        else
        begin
            o_done           <= 1'b0;
            o_ser_count_done <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (i_go)
                    begin
                        state      <= ST_START;
                        o_ser_en   <= 1'b1;
                        o_ser_mode <= START_BIT;
                        o_busy     <= 1'b1;
                    end
                end
                ST_START:
                begin
                    // hold time met, let scl run into the first bit
                    if (i_ser_mode_done)
                    begin
                        state       <= ST_DATA;
                        o_scl_run   <= 1'b1;
                        o_ser_mode  <= SERIALIZING;
                        o_ser_count <= 3'd7;
                        first_fall  <= 1'b1;
                    end
                end
                ST_DATA:
                begin
                    if (i_scl_neg_edge)
                    begin
                        if (first_fall)
                        begin
                            first_fall <= 1'b0;
                        end
                        else if (o_ser_count == 3'd0)
                        begin
                            state            <= ST_PARITY;
                            o_ser_mode       <= PARITY;
                            o_ser_count_done <= 1'b1;
                        end
                        else
                        begin
                            o_ser_count <= o_ser_count - 1'b1;
                        end
                    end
                end
                ST_PARITY:
                begin
                    if (i_scl_neg_edge)
                    begin
                        state      <= ST_END;
                        o_ser_mode <= cfg_q.rep_start ? REPEATED_START : STOP;
                    end
                end
                ST_END:
                begin
                    // freeze scl high once it has risen
                    if (i_scl_pos_edge)
                    begin
                        o_scl_run <= 1'b0;
                    end
                    // ignore the T-bit done that arrives while scl still runs
                    if (i_ser_mode_done && !o_scl_run)
                    begin
                        state  <= ST_IDLE;
                        o_busy <= 1'b0;
                        o_done <= 1'b1;
                        // after a repeated start the serializer stays on to keep sda low
                        o_ser_en <= cfg_q.rep_start;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/controller_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module controller_tx
    import i3c_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_ser_scl,
    input  logic       i_ser_scl_pos_edge,
    input  logic       i_ser_scl_neg_edge,
    input  logic       i_ser_en,
    input  ser_mode_e  i_ser_mode,
    input  logic [2:0] i_ser_count,
    input  logic       i_ser_count_done,
    input  logic [7:0] i_ser_regf_data,
    input  logic       i_timer_cas,
    output logic       o_start_pattern,
    output logic       o_stop_pattern,
    output logic       o_ser_s_data,
    output logic       o_ser_mode_done
);

    // ==========================================================================
    // sda serializer
    // ==========================================================================
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            o_start_pattern <= 1'b0;
            o_stop_pattern  <= 1'b0;
            o_ser_s_data    <= 1'b1;
            o_ser_mode_done <= 1'b0;
        end
        else if (i_ser_en)
        begin
            case (i_ser_mode)
                START_BIT:
                begin
                    o_stop_pattern  <= 1'b0;
                    o_start_pattern <= 1'b0;
                    o_ser_mode_done <= 1'b0;
                    if (i_ser_scl)
                    begin
                        o_ser_s_data <= 1'b0;
                        // ask the timer for the hold, done once it answers
                        if (!o_ser_mode_done)
                        begin
                            if (i_timer_cas)
                            begin
                                o_ser_mode_done <= 1'b1;
                            end
                            else
                            begin
                                o_start_pattern <= 1'b1;
                            end
                        end
                    end
                    else
                    begin
                        o_ser_s_data <= 1'b1;
                    end
                end
                SERIALIZING:
                begin
                    o_start_pattern <= 1'b0;
                    o_stop_pattern  <= 1'b0;
                    o_ser_mode_done <= i_ser_count_done;
                    // new bit only while scl is low
                    if (!i_ser_scl)
                    begin
                        o_ser_s_data <= i_ser_regf_data[i_ser_count];
                    end
                end
                PARITY:
                begin
                    o_start_pattern <= 1'b0;
                    o_stop_pattern  <= 1'b0;
                    o_ser_mode_done <= i_ser_scl_neg_edge;
                    if (!i_ser_scl)
                    begin
                        // T-bit, odd parity over the byte
                        o_ser_s_data <= ~^i_ser_regf_data;
                    end
                end
                STOP:
                begin
                    o_start_pattern <= 1'b0;
                    o_ser_mode_done <= 1'b0;
                    o_ser_s_data    <= 1'b0;
                    if (i_ser_scl)
                    begin
                        o_ser_s_data    <= 1'b1;
                        o_stop_pattern  <= 1'b1;
                        o_ser_mode_done <= !o_ser_mode_done;
                    end
                end
                REPEATED_START:
                begin
                    o_start_pattern <= 1'b0;
                    o_stop_pattern  <= 1'b0;
                    // high through the low phase, falls once scl is high
                    o_ser_s_data    <= !i_ser_scl;
                    o_ser_mode_done <= i_ser_scl_pos_edge;
                end
                default:
                begin
                    o_start_pattern <= 1'b0;
                    o_stop_pattern  <= 1'b0;
                    o_ser_mode_done <= 1'b0;
                end
            endcase
        end
        else
        begin
            // idle bus
            o_start_pattern <= 1'b0;
            o_stop_pattern  <= 1'b0;
            o_ser_s_data    <= 1'b1;
            o_ser_mode_done <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/i3c_tx_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module i3c_tx_top
    import i3c_tx_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_wr_en,
    input  logic       i_wr_addr,
    input  logic [7:0] i_wr_data,
    output logic       o_scl,
    output logic       o_sda,
    output logic       o_busy,
    output logic       o_done
);

    tx_cfg_t    cfg;
    logic       go;
    logic       ser_en;
    ser_mode_e  ser_mode;
    logic [2:0] ser_count;
    logic       ser_count_done;
    logic [7:0] ser_data;
    logic       ser_mode_done;
    logic       scl_run;
    logic       scl_pos_edge;
    logic       scl_neg_edge;
    logic       start_pattern;
    logic       timer_cas;

    tx_cfg_regs u_regs (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .o_cfg     (cfg),
        .o_go      (go)
    );

    frame_sequencer u_seq (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_cfg            (cfg),
        .i_go             (go),
        .i_scl_pos_edge   (scl_pos_edge),
        .i_scl_neg_edge   (scl_neg_edge),
        .i_ser_mode_done  (ser_mode_done),
        .o_ser_en         (ser_en),
        .o_ser_mode       (ser_mode),
        .o_ser_count      (ser_count),
        .o_ser_count_done (ser_count_done),
        .o_ser_data       (ser_data),
        .o_scl_run        (scl_run),
        .o_busy           (o_busy),
        .o_done           (o_done)
    );

    scl_gen u_scl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_run          (scl_run),
        .o_scl          (o_scl),
        .o_scl_pos_edge (scl_pos_edge),
        .o_scl_neg_edge (scl_neg_edge)
    );

    start_hold_timer u_timer (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_start_pattern (start_pattern),
        .o_timer_cas     (timer_cas)
    );

    // stop pattern has no consumer in the transmit-only path
    controller_tx u_ser (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_ser_scl          (o_scl),
        .i_ser_scl_pos_edge (scl_pos_edge),
        .i_ser_scl_neg_edge (scl_neg_edge),
        .i_ser_en           (ser_en),
        .i_ser_mode         (ser_mode),
        .i_ser_count        (ser_count),
        .i_ser_count_done   (ser_count_done),
        .i_ser_regf_data    (ser_data),
        .i_timer_cas        (timer_cas),
        .o_start_pattern    (start_pattern),
        .o_stop_pattern     (),
        .o_ser_s_data       (o_sda),
        .o_ser_mode_done    (ser_mode_done)
    );

endmodule

`default_nettype wire

// ==== tb/i3c_tx_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module i3c_tx_assert
(
    input logic i_clk,
    input logic i_rst_n,
    input logic i_scl,
    input logic i_sda,
    input logic i_busy,
    input logic i_done
);

    // number of assertion failures so far
    int         fail_cnt = 0;
    logic       scl_q;
    logic [3:0] fall_cnt;

    // scl falls since the frame began, falls 1 to 9 open a data or T-bit phase
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            scl_q    <= 1'b1;
            fall_cnt <= '0;
        end
        else
        begin
            scl_q <= i_scl;
            if (!i_busy)
            begin
                fall_cnt <= '0;
            end
            else if (scl_q && !i_scl && fall_cnt != 4'hf)
            begin
                fall_cnt <= fall_cnt + 4'd1;
            end
        end
    end

    // ==========================================================================
    // bus protocol
    // ==========================================================================
    // inside a frame only start and stop edges may move sda with scl high
    a_sda_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_scl && scl_q && fall_cnt >= 4'd1 && fall_cnt <= 4'd9) |-> $stable(i_sda))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("sda changed while scl was high during a data or T-bit");
    end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |=> !i_done)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("o_done stayed high for more than one cycle");
    end

    // busy drops in the same cycle as done
    a_done_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_done |-> !i_busy)
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("o_busy still high while o_done pulses");
    end

    a_reset_idle: assert property (@(posedge i_clk)
        !$past(i_rst_n) |-> (!i_busy && !i_done))
    else
    begin
        fail_cnt = fail_cnt + 1;
        $error("o_busy or o_done high straight after reset");
    end

endmodule

bind i3c_tx_top i3c_tx_assert u_assert (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_scl   (o_scl),
    .i_sda   (o_sda),
    .i_busy  (o_busy),
    .i_done  (o_done)
);

`default_nettype wire

// ==== tb/tb_i3c_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_i3c_tx
    import i3c_tx_pkg::*;
();

    localparam int N_FRAMES   = 20;
    localparam int FRAME_CYC  = 30 * SCL_HALF_CYC + 20;
    localparam int CLK_PERIOD = 100;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        wr_en;
    logic        wr_addr;
    logic [7:0]  wr_data;
    logic        scl;
    logic        sda;
    logic        busy;
    logic        done;

    // bus monitor state
    logic        seen_bits[$];
    logic        scl_q;
    logic        sda_q;
    logic        start_seen;
    int          fall_cnt;
    int          done_cnt;
    logic [31:0] lfsr_state;

    i3c_tx_top dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_scl     (scl),
        .o_sda     (sda),
        .o_busy    (busy),
        .o_done    (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_failure(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    // galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
        begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] val);
        int i;
        val = 8'h00;
        for (i = 0; i < n; i++)
        begin
            val        = {val[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // 1 when the byte holds an even number of ones
    function automatic logic expected_parity(input logic [7:0] b);
        int         ones;
        logic [7:0] tmp;
        ones = 0;
        tmp  = b;
        repeat (8)
        begin
            if (tmp[0])
            begin
                ones = ones + 1;
            end
            tmp = tmp >> 1;
        end
        return (ones % 2) == 0;
    endfunction

    task automatic write_reg(input logic addr, input logic [7:0] data);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    task automatic wait_rises(input int n);
        int cycles;
        cycles = 0;
        while (seen_bits.size() < n)
        begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > FRAME_CYC)
            begin
                report_failure($sformatf("only %0d SCL rises seen, waiting for %0d",
                    seen_bits.size(), n));
            end
        end
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (!done)
        begin
            @(negedge clk);
            cycles = cycles + 1;
            if (cycles > FRAME_CYC)
            begin
                report_failure("o_done never came within the frame time limit");
            end
        end
    endtask

    task automatic check_idle(input logic sda_level, input string where);
        assert (scl === 1'b1 && sda === sda_level && busy === 1'b0 && done === 1'b0)
        else report_failure($sformatf("bus not idle %s: scl=%b sda=%b busy=%b done=%b",
            where, scl, sda, busy, done));
    endtask

    task automatic check_frame(input logic [7:0] exp_byte, input logic exp_rep);
        int i;
        assert (seen_bits.size() == 10)
        else report_failure($sformatf("expected 10 SCL rises in the frame, saw %0d",
            seen_bits.size()));
        for (i = 0; i < 8; i++)
        begin
            assert (seen_bits[i] === exp_byte[3'(7 - i)])
            else report_failure($sformatf("byte %02h bit %0d: expected %b, saw %b",
                exp_byte, 7 - i, exp_byte[3'(7 - i)], seen_bits[i]));
        end
        assert (seen_bits[8] === expected_parity(exp_byte))
        else report_failure($sformatf("byte %02h T-bit: expected %b, saw %b",
            exp_byte, expected_parity(exp_byte), seen_bits[8]));
        // stop drives sda low in the last low phase, repeated start keeps it high
        assert (seen_bits[9] === exp_rep)
        else report_failure($sformatf("sda before the end condition: expected %b, saw %b",
            exp_rep, seen_bits[9]));
    endtask

    // ==========================================================================
    // bus monitor, sampled on the falling clock edge
    // ==========================================================================
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert (dut.u_assert.fail_cnt == 0)
            else report_failure("a bus protocol assertion fired");
            if (!scl_q && scl)
            begin
                seen_bits.push_back(sda);
            end
            if (scl_q && scl && sda_q && !sda)
            begin
                start_seen = 1'b1;
            end
            if (scl_q && !scl)
            begin
                if (fall_cnt == 0)
                begin
                    assert (start_seen)
                    else report_failure("first SCL fall of the frame came without a START");
                end
                start_seen = 1'b0;
                fall_cnt   = fall_cnt + 1;
            end
            if (done)
            begin
                done_cnt = done_cnt + 1;
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

    // ==========================================================================
    // stimulus
    // ==========================================================================
    initial
    begin : stimulus
        logic [7:0] tx_byte;
        logic [7:0] rep_bits;
        logic [7:0] junk;
        logic [7:0] gap;
        logic       rep;
        int         f;
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = 1'b0;
        wr_data    = 8'h00;
        lfsr_state = 32'hfb43948b;
        scl_q      = 1'b1;
        sda_q      = 1'b1;
        start_seen = 1'b0;
        fall_cnt   = 0;
        done_cnt   = 0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle(1'b1, "after reset");

        for (f = 0; f < N_FRAMES; f++)
        begin
            take_bits(8, tx_byte);
            take_bits(1, rep_bits);
            rep = rep_bits[0];
            write_reg(REG_DATA, tx_byte);
            seen_bits.delete();
            fall_cnt = 0;
            done_cnt = 0;
            write_reg(REG_CTRL, {6'd0, 1'b1, rep});
            if (f % 4 == 3)
            begin
                // new byte, flipped ending and a second go in mid frame
                wait_rises(3);
                take_bits(8, junk);
                write_reg(REG_DATA, junk);
                write_reg(REG_CTRL, {6'd0, 1'b1, ~rep});
            end
            wait_done();
            assert (scl === 1'b1 && sda === ~rep && busy === 1'b0)
            else report_failure($sformatf("end of frame: scl=%b sda=%b busy=%b, rep_start=%b",
                scl, sda, busy, rep));
            check_frame(tx_byte, rep);
            take_bits(2, gap);
            repeat (gap + 1)
            begin
                @(negedge clk);
                check_idle(~rep, "between frames");
            end
            assert (done_cnt == 1)
            else report_failure($sformatf("o_done pulsed %0d times in one frame", done_cnt));
        end

        if (dut.u_assert.fail_cnt == 0)
        begin
            $display("Test completed successfully");
            $finish;
        end
        else
        begin
            report_failure("bus protocol assertions fired during the run");
        end
    end

    initial
    begin : watchdog
        #(N_FRAMES * FRAME_CYC * CLK_PERIOD);
        $display("watchdog: the run did not finish within %0d cycles",
            N_FRAMES * FRAME_CYC);
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/i3c_tx_pkg.sv
source/tx_cfg_regs.sv
source/scl_gen.sv
source/start_hold_timer.sv
source/frame_sequencer.sv
source/controller_tx.sv
source/i3c_tx_top.sv
tb/i3c_tx_assert.sv
tb/tb_i3c_tx.sv

// ==== Makefile ====
TOP := tb_i3c_tx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -Mdir obj_dir -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
